// File: Bender.yml
package:
  name: fetch_frontend

sources:
  - hw/fetch_pkg.sv
  - hw/fetch_predecode.sv
  - hw/jalr_target_table.sv
  - hw/pc_ctrl_super.sv
  - hw/fetch_top.sv
  - target: test
    files:
      - tests/fetch_checker.sv
      - tests/fetch_assertions.sv
      - tests/tb_fetch.sv

// File: hw/fetch_pkg.sv
package fetch_pkg;

	//////////////////////////////
	// Widths and geometry
	//////////////////////////////

	localparam int PC_W        = 32;
	localparam int NUM_SLOTS   = 5;
	localparam int INST_BYTES  = 4;
	localparam int BTB_ENTRIES = 8;
	localparam int BTB_IDX_W   = 3;
	// Tag covers the PC bits above the index and the byte offset
	localparam int BTB_TAG_W   = PC_W - BTB_IDX_W - 2;

	typedef logic [PC_W-1:0]      addr_t;
	typedef logic [31:0]          inst_t;
	typedef logic [PC_W-1:0]      imm_t;
	typedef logic [6:0]           opcode_t;
	typedef logic [BTB_IDX_W-1:0] btb_idx_t;
	typedef logic [BTB_TAG_W-1:0] btb_tag_t;

	localparam addr_t   RESET_PC = 32'h0000_0000;
	localparam opcode_t OPC_JAL  = 7'b1101111;
	localparam opcode_t OPC_JALR = 7'b1100111;

	//////////////////////////////
	// Bundles and structs
	//////////////////////////////

	// Slot 0 sits in the lowest bits
	typedef inst_t [NUM_SLOTS-1:0] fetch_bundle_t;
	typedef addr_t [NUM_SLOTS-1:0] addr_vec_t;

	typedef struct packed {
		logic jal;
		logic jalr;
		imm_t imm;
	} slot_info_t;

	typedef slot_info_t [NUM_SLOTS-1:0] slot_info_vec_t;

	// Resolution coming back from execute
	typedef struct packed {
		logic  mispredict;
		logic  is_jalr;
		addr_t jalr_pc;
		addr_t correct_pc;
	} resolve_t;

	typedef struct packed {
		addr_vec_t inst_addr;
		addr_vec_t current_pc;
		addr_vec_t pc_save;
	} fetch_out_t;

endpackage

// File: hw/fetch_predecode.sv
module fetch_predecode (
	input  fetch_pkg::fetch_bundle_t  bundle,
	output fetch_pkg::slot_info_vec_t slots
);

	for (genvar i = 0; i < fetch_pkg::NUM_SLOTS; i++) begin : g_slot
		fetch_pkg::inst_t   word;
		fetch_pkg::opcode_t opcode;
		logic               is_jal;
		logic               is_jalr;
		fetch_pkg::imm_t    imm_j;
		fetch_pkg::imm_t    imm_i;
		fetch_pkg::imm_t    imm_sel;

		assign word   = bundle[i];
		assign opcode = word[6:0];

		assign is_jal  = (opcode == fetch_pkg::OPC_JAL);
		assign is_jalr = (opcode == fetch_pkg::OPC_JALR);

		// J-type, bit 0 always zero
		assign imm_j = {
			{11{word[31]}},
			word[31],
			word[19:12],
			word[20],
			word[30:21],
			1'b0
		};

		// I-type, sign extended from bit 31
		assign imm_i = {{20{word[31]}}, word[31:20]};

		always_comb begin
			if (is_jal) begin
				imm_sel = imm_j;
			end else if (is_jalr) begin
				imm_sel = imm_i;
			end else begin
				imm_sel = '0;
			end
		end

		assign slots[i] = '{
			jal:  is_jal,
			jalr: is_jalr,
			imm:  imm_sel
		};
	end

endmodule

// File: hw/fetch_top.sv
module fetch_top (
	input  logic                     clk,
	input  logic                     reset,
	input  fetch_pkg::fetch_bundle_t bundle,
	input  logic                     parallel_mode,
	input  logic                     bubble,
	input  fetch_pkg::resolve_t      resolve,
	output fetch_pkg::fetch_out_t    out
);

	fetch_pkg::slot_info_vec_t slots;
	fetch_pkg::addr_t          jalr_lookup_pc;
	logic                      pred_hit;
	fetch_pkg::addr_t          pred_target;

	fetch_predecode u_predecode (
		.bundle (bundle),
		.slots  (slots)
	);

	// JALR target prediction, trained by execute
	jalr_target_table u_jalr_table (
		.clk         (clk),
		.reset       (reset),
		.lookup_pc   (jalr_lookup_pc),
		.resolve     (resolve),
		.pred_hit    (pred_hit),
		.pred_target (pred_target)
	);

	pc_ctrl_super u_pc_ctrl (
		.clk            (clk),
		.reset          (reset),
		.bubble         (bubble),
		.parallel_mode  (parallel_mode),
		.slots          (slots),
		.pred_hit       (pred_hit),
		.pred_target    (pred_target),
		.resolve        (resolve),
		.jalr_lookup_pc (jalr_lookup_pc),
		.out            (out)
	);

endmodule

// File: hw/jalr_target_table.sv
module jalr_target_table (
	input  logic                clk,
	input  logic                reset,
	input  fetch_pkg::addr_t    lookup_pc,
	input  fetch_pkg::resolve_t resolve,
	output logic                pred_hit,
	output fetch_pkg::addr_t    pred_target
);

	logic [fetch_pkg::BTB_ENTRIES-1:0] valid_q;
	fetch_pkg::btb_tag_t               tag_mem [fetch_pkg::BTB_ENTRIES];
	fetch_pkg::addr_t                  target_mem [fetch_pkg::BTB_ENTRIES];

	fetch_pkg::btb_idx_t rd_idx;
	fetch_pkg::btb_tag_t rd_tag;
	fetch_pkg::btb_idx_t wr_idx;
	fetch_pkg::btb_tag_t wr_tag;
	logic                wr_en;

	//////////////////////////////
	// Lookup
	//////////////////////////////

	assign rd_idx = lookup_pc[fetch_pkg::BTB_IDX_W+1:2];
	assign rd_tag = lookup_pc[fetch_pkg::PC_W-1:fetch_pkg::BTB_IDX_W+2];

	assign pred_hit    = valid_q[rd_idx] && (tag_mem[rd_idx] == rd_tag);
	assign pred_target = target_mem[rd_idx];

	//////////////////////////////
	// Update from execute
	//////////////////////////////

	// Only a resolved JALR that went wrong trains the table
	assign wr_en  = resolve.mispredict && resolve.is_jalr;
	assign wr_idx = resolve.jalr_pc[fetch_pkg::BTB_IDX_W+1:2];
	assign wr_tag = resolve.jalr_pc[fetch_pkg::PC_W-1:fetch_pkg::BTB_IDX_W+2];

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			valid_q <= '0;
		end else if (wr_en) begin
			valid_q[wr_idx] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr_en) begin
			tag_mem[wr_idx]    <= wr_tag;
			target_mem[wr_idx] <= resolve.correct_pc;
		end
	end

endmodule

// File: hw/pc_ctrl_super.sv
module pc_ctrl_super (
	input  logic                      clk,
	input  logic                      reset,
	input  logic                      bubble,
	input  logic                      parallel_mode,
	input  fetch_pkg::slot_info_vec_t slots,
	input  logic                      pred_hit,
	input  fetch_pkg::addr_t          pred_target,
	input  fetch_pkg::resolve_t       resolve,
	output fetch_pkg::addr_t          jalr_lookup_pc,
	output fetch_pkg::fetch_out_t     out
);

	fetch_pkg::addr_t pc_q;
	fetch_pkg::addr_t fetch_pc;
	fetch_pkg::addr_t fetch_addr;
	fetch_pkg::addr_t next_pc;
	fetch_pkg::addr_t seq_pc;
	fetch_pkg::addr_t jal_target;
	fetch_pkg::addr_t jalr_target;

	// First control transfer in the bundle
	logic             xfer_found;
	logic             xfer_is_jalr;
	fetch_pkg::addr_t xfer_pc;
	fetch_pkg::imm_t  xfer_imm;
	logic             jalr_found;

	logic [fetch_pkg::NUM_SLOTS-1:0] slot_xfer;
	fetch_pkg::addr_vec_t            slot_pc;
	fetch_pkg::addr_vec_t            inst_addr;
	fetch_pkg::addr_vec_t            pc_save;

	//////////////////////////////
	// Slot PCs and priority
	//////////////////////////////

	always_comb begin
		for (int i = 0; i < fetch_pkg::NUM_SLOTS; i++) begin
			slot_pc[i]   = parallel_mode ? pc_q + fetch_pkg::addr_t'(fetch_pkg::INST_BYTES * i)
			                             : pc_q;
			slot_xfer[i] = slots[i].jal | slots[i].jalr;
		end
	end

	// Scalar mode looks at slot 0 only
	always_comb begin
		xfer_found   = 1'b0;
		xfer_is_jalr = 1'b0;
		xfer_pc      = pc_q;
		xfer_imm     = '0;
		for (int i = 0; i < fetch_pkg::NUM_SLOTS; i++) begin
			if (!xfer_found && slot_xfer[i] && (parallel_mode || i == 0)) begin
				xfer_found   = 1'b1;
				xfer_is_jalr = slots[i].jalr;
				xfer_pc      = slot_pc[i];
				xfer_imm     = slots[i].imm;
			end
		end
	end

	always_comb begin
		jalr_found     = 1'b0;
		jalr_lookup_pc = slot_pc[0];
		for (int i = 0; i < fetch_pkg::NUM_SLOTS; i++) begin
			if (!jalr_found && slots[i].jalr && (parallel_mode || i == 0)) begin
				jalr_found     = 1'b1;
				jalr_lookup_pc = slot_pc[i];
			end
		end
	end

	//////////////////////////////
	// Next PC
	//////////////////////////////

	assign jal_target  = xfer_pc + {xfer_imm[fetch_pkg::PC_W-1:2], 2'b00};
	// Table miss falls through to the next word
	assign jalr_target = pred_hit ? pred_target
	                              : xfer_pc + fetch_pkg::addr_t'(fetch_pkg::INST_BYTES);

	assign seq_pc = pc_q + fetch_pkg::addr_t'(parallel_mode
		? fetch_pkg::NUM_SLOTS * fetch_pkg::INST_BYTES
		: fetch_pkg::INST_BYTES);

	assign next_pc = !xfer_found  ? seq_pc
	               : xfer_is_jalr ? jalr_target
	               :                jal_target;

	// Mispredict wins over bubble
	assign fetch_pc = resolve.mispredict ? resolve.correct_pc
	                : bubble             ? pc_q
	                :                      next_pc;

	assign fetch_addr = reset ? fetch_pc : fetch_pkg::RESET_PC;

	always_ff @(posedge clk or negedge reset) begin
		if (!reset) begin
			pc_q <= fetch_pkg::RESET_PC;
		end else begin
			pc_q <= fetch_pc;
		end
	end

	//////////////////////////////
	// Per-slot outputs
	//////////////////////////////

	always_comb begin
		for (int i = 0; i < fetch_pkg::NUM_SLOTS; i++) begin
			inst_addr[i] = parallel_mode
				? fetch_addr + fetch_pkg::addr_t'(fetch_pkg::INST_BYTES * i)
				: fetch_addr;
			// Link value for jumps, AUIPC-style sum otherwise
			pc_save[i] = slot_xfer[i]
				? slot_pc[i] + fetch_pkg::addr_t'(fetch_pkg::INST_BYTES)
				: slot_pc[i] + {slots[i].imm[fetch_pkg::PC_W-1:2], 2'b00};
		end
	end

	assign out = '{
		inst_addr:  inst_addr,
		current_pc: slot_pc,
		pc_save:    pc_save
	};

endmodule

// File: tb.f
hw/fetch_pkg.sv
hw/fetch_predecode.sv
hw/jalr_target_table.sv
hw/pc_ctrl_super.sv
hw/fetch_top.sv
tests/fetch_checker.sv
tests/fetch_assertions.sv
tests/tb_fetch.sv

// File: tests/fetch_assertions.sv
module fetch_assertions (
	input logic                  clk,
	input logic                  reset,
	input logic                  bubble,
	input fetch_pkg::resolve_t   resolve,
	input fetch_pkg::fetch_out_t out
);

	fetch_pkg::addr_t pc0;
	int               fail_count = 0;

	assign pc0 = out.current_pc[0];

	a_pc_aligned: assert property (@(posedge clk) disable iff (!reset)
		pc0[1:0] == 2'b00)
		else begin
			fail_count++;
			$error("current_pc slot 0 is not word-aligned: %h", pc0);
		end

	// Bubble freezes the PC unless execute redirects
	a_bubble_hold: assert property (@(posedge clk) disable iff (!reset)
		bubble && !resolve.mispredict |=> pc0 == $past(pc0))
		else begin
			fail_count++;
			$error("PC moved during a bubble: now %h", pc0);
		end

	a_mispredict_load: assert property (@(posedge clk) disable iff (!reset)
		resolve.mispredict |=> pc0 == $past(resolve.correct_pc))
		else begin
			fail_count++;
			$error("PC %h does not match the corrected PC after a mispredict", pc0);
		end

endmodule

bind pc_ctrl_super fetch_assertions u_assertions (
	.clk     (clk),
	.reset   (reset),
	.bubble  (bubble),
	.resolve (resolve),
	.out     (out)
);

// File: tests/fetch_checker.sv
module fetch_checker (
	input  logic                     clk,
	input  logic                     reset,
	input  fetch_pkg::fetch_bundle_t bundle,
	input  logic                     parallel_mode,
	input  logic                     bubble,
	input  fetch_pkg::resolve_t      resolve,
	input  fetch_pkg::fetch_out_t    fetch_out,
	output int                       inst_errors,
	output int                       pc_errors,
	output int                       save_errors
);

	typedef fetch_pkg::addr_t [fetch_pkg::BTB_ENTRIES-1:0] tbl_addr_t;

	// Model state, one entry per table index
	fetch_pkg::addr_t                  model_pc = fetch_pkg::RESET_PC;
	logic [fetch_pkg::BTB_ENTRIES-1:0] tbl_valid = '0;
	tbl_addr_t                         tbl_pc;
	tbl_addr_t                         tbl_target;

	// J-type for JAL, I-type for JALR, zero otherwise
	function automatic fetch_pkg::imm_t slot_imm(input fetch_pkg::inst_t w);
		logic [20:0] j_imm;
		j_imm = {w[31], w[19:12], w[20], w[30:21], 1'b0};
		if (w[6:0] == fetch_pkg::OPC_JAL) begin
			return fetch_pkg::imm_t'($signed(j_imm));
		end else if (w[6:0] == fetch_pkg::OPC_JALR) begin
			return fetch_pkg::imm_t'($signed(w[31:20]));
		end
		return '0;
	endfunction

	function automatic fetch_pkg::fetch_out_t next_fetch(
		input fetch_pkg::fetch_bundle_t          b,
		input logic                              par,
		input logic                              bub,
		input fetch_pkg::resolve_t               res,
		input logic                              rst_n,
		input fetch_pkg::addr_t                  pc,
		input logic [fetch_pkg::BTB_ENTRIES-1:0] t_valid,
		input tbl_addr_t                         t_pc,
		input tbl_addr_t                         t_target
	);
		fetch_pkg::fetch_out_t r;
		fetch_pkg::addr_t      nxt;
		fetch_pkg::addr_t      fa;
		fetch_pkg::addr_t      cur;
		fetch_pkg::imm_t       imm;
		logic                  xfer;
		logic                  found;
		int                    idx;
		found = 1'b0;
		nxt   = pc + (par ? 32'd20 : 32'd4);
		for (int i = 0; i < fetch_pkg::NUM_SLOTS; i++) begin
			cur  = par ? pc + 32'(4 * i) : pc;
			imm  = slot_imm(b[i]);
			xfer = (b[i][6:0] == fetch_pkg::OPC_JAL) || (b[i][6:0] == fetch_pkg::OPC_JALR);
			r.current_pc[i] = cur;
			r.pc_save[i]    = xfer ? cur + 32'd4 : cur + (imm & ~32'd3);
			if (xfer && !found && (par || i == 0)) begin
				found = 1'b1;
				idx   = cur[4:2];
				if (b[i][6:0] == fetch_pkg::OPC_JAL) begin
					nxt = cur + (imm & ~32'd3);
				end else if (t_valid[idx] && t_pc[idx][31:5] == cur[31:5]) begin
					nxt = t_target[idx];
				end else begin
					nxt = cur + 32'd4;
				end
			end
		end
		if (!rst_n) begin
			fa = fetch_pkg::RESET_PC;
		end else if (res.mispredict) begin
			fa = res.correct_pc;
		end else if (bub) begin
			fa = pc;
		end else begin
			fa = nxt;
		end
		for (int i = 0; i < fetch_pkg::NUM_SLOTS; i++) begin
			r.inst_addr[i] = par ? fa + 32'(4 * i) : fa;
		end
		return r;
	endfunction

	function automatic string cycle_kind(input logic rst_n, input logic par, input logic bub,
	                                     input fetch_pkg::resolve_t res,
	                                     input fetch_pkg::fetch_bundle_t b);
		if (!rst_n) return "reset";
		if (res.mispredict) return "mispredict";
		if (bub) return "bubble";
		for (int i = 0; i < (par ? fetch_pkg::NUM_SLOTS : 1); i++) begin
			if (b[i][6:0] == fetch_pkg::OPC_JAL) return "jal_priority";
			if (b[i][6:0] == fetch_pkg::OPC_JALR) return "jalr_predict";
		end
		return par ? "sequential_parallel" : "sequential_scalar";
	endfunction

	task automatic check_vec(input string test, input string field,
	                         input fetch_pkg::addr_vec_t expected,
	                         input fetch_pkg::addr_vec_t actual, output int bad);
		bad = 0;
		for (int i = 0; i < fetch_pkg::NUM_SLOTS; i++) begin
			if (expected[i] !== actual[i]) begin
				$display("** Error [%s] %s slot %0d: expected %h, actual %h",
					test, field, i, expected[i], actual[i]);
				bad++;
			end
		end
	endtask

	initial begin
		inst_errors = 0;
		pc_errors   = 0;
		save_errors = 0;
	end

	//////////////////////////////
	// Compare at mid-cycle
	//////////////////////////////

	always @(negedge clk) begin : compare
		fetch_pkg::fetch_out_t exp_out;
		fetch_pkg::btb_idx_t   wr_idx;
		string                 test;
		int                    bad;
		if (!reset) begin
			model_pc = fetch_pkg::RESET_PC;
		end
		exp_out = next_fetch(bundle, parallel_mode, bubble, resolve, reset, model_pc,
			tbl_valid, tbl_pc, tbl_target);
		test = cycle_kind(reset, parallel_mode, bubble, resolve, bundle);
		check_vec(test, "inst_addr", exp_out.inst_addr, fetch_out.inst_addr, bad);
		inst_errors += bad;
		check_vec(test, "current_pc", exp_out.current_pc, fetch_out.current_pc, bad);
		pc_errors += bad;
		check_vec(test, "pc_save", exp_out.pc_save, fetch_out.pc_save, bad);
		save_errors += bad;
		// Advance the model to what the coming edge stores
		if (!reset) begin
			tbl_valid = '0;
		end else begin
			model_pc = exp_out.inst_addr[0];
			if (resolve.mispredict && resolve.is_jalr) begin
				wr_idx             = resolve.jalr_pc[4:2];
				tbl_valid[wr_idx]  = 1'b1;
				tbl_pc[wr_idx]     = resolve.jalr_pc;
				tbl_target[wr_idx] = resolve.correct_pc;
			end
		end
	end

endmodule

// File: tests/tb_fetch.sv
module tb_fetch;

	localparam int STIM_CYCLES    = 1000;
	localparam int TIMEOUT_CYCLES = STIM_CYCLES + 50;
	localparam int MODE_PERIOD    = 200;

	logic                     clk;
	logic                     reset;
	fetch_pkg::fetch_bundle_t bundle;
	logic                     parallel_mode;
	logic                     bubble;
	fetch_pkg::resolve_t      resolve;
	fetch_pkg::fetch_out_t    fetch_out;
	fetch_pkg::addr_t         recent_jalr_pc;
	int                       inst_errors;
	int                       pc_errors;
	int                       save_errors;

	fetch_top uut (
		.clk           (clk),
		.reset         (reset),
		.bundle        (bundle),
		.parallel_mode (parallel_mode),
		.bubble        (bubble),
		.resolve       (resolve),
		.out           (fetch_out)
	);

	fetch_checker u_checker (
		.clk           (clk),
		.reset         (reset),
		.bundle        (bundle),
		.parallel_mode (parallel_mode),
		.bubble        (bubble),
		.resolve       (resolve),
		.fetch_out     (fetch_out),
		.inst_errors   (inst_errors),
		.pc_errors     (pc_errors),
		.save_errors   (save_errors)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	//////////////////////////////
	// Stimulus helpers
	//////////////////////////////

	// One in ten JAL, one in ten JALR, the rest AUIPC-like
	function automatic fetch_pkg::inst_t random_slot_word();
		int unsigned pick;
		logic [20:0] off;
		logic [31:0] r;
		pick = $urandom_range(9, 0);
		r    = $urandom;
		if (pick == 0) begin
			// Short jump, bit 1 sometimes set
			off = 21'($urandom_range(127, 0)) * 21'd2 - 21'd128;
			return {off[20], off[10:1], off[11], off[19:12], r[11:7], fetch_pkg::OPC_JAL};
		end else if (pick == 1) begin
			return {r[31:7], fetch_pkg::OPC_JALR};
		end
		return {r[31:7], 7'b0010111};
	endfunction

	task automatic drive_cycle(input int cyc);
		fetch_pkg::fetch_bundle_t b;
		fetch_pkg::resolve_t      r;
		logic                     mode;
		mode = ((cyc / MODE_PERIOD) % 2) == 0;
		for (int i = 0; i < fetch_pkg::NUM_SLOTS; i++) begin
			b[i] = random_slot_word();
		end
		// Scalar mode shows slot 0 everywhere
		if (!mode) begin
			for (int i = 1; i < fetch_pkg::NUM_SLOTS; i++) begin
				b[i] = b[0];
			end
		end
		r = '0;
		if ($urandom_range(9, 0) == 0) begin
			r.mispredict = 1'b1;
			// Keep redirects in a small window so JALR PCs come back
			r.correct_pc = fetch_pkg::addr_t'($urandom_range(63, 0)) << 2;
			if ($urandom_range(1, 0) == 1) begin
				r.is_jalr = 1'b1;
				r.jalr_pc = recent_jalr_pc;
			end
		end
		bundle        <= b;
		parallel_mode <= mode;
		bubble        <= ($urandom_range(7, 0) == 0);
		resolve       <= r;
	endtask

	// Last JALR slot address seen, used to train the table
	always @(negedge clk) begin
		for (int i = 0; i < fetch_pkg::NUM_SLOTS; i++) begin
			if (bundle[i][6:0] == fetch_pkg::OPC_JALR && (parallel_mode || i == 0)) begin
				recent_jalr_pc <= fetch_out.current_pc[i];
			end
		end
	end

	//////////////////////////////
	// Run control
	//////////////////////////////

	initial begin
		int total;
		int assert_errors;
		void'($urandom(60043));
		reset          = 1'b0;
		bundle         = '0;
		parallel_mode  = 1'b1;
		bubble         = 1'b0;
		resolve        = '0;
		recent_jalr_pc = fetch_pkg::RESET_PC;
		repeat (3) @(posedge clk);
		reset <= 1'b1;
		for (int cyc = 0; cyc < STIM_CYCLES; cyc++) begin
			drive_cycle(cyc);
			@(posedge clk);
		end
		@(negedge clk);
		@(posedge clk);
		assert_errors = uut.u_pc_ctrl.u_assertions.fail_count;
		total = inst_errors + pc_errors + save_errors + assert_errors;
		$display("Errors: inst_addr %0d, current_pc %0d, pc_save %0d, assertions %0d, total %0d",
			inst_errors, pc_errors, save_errors, assert_errors, total);
		if (total == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

	initial begin
		int cycles;
		cycles = 0;
		while (cycles <= TIMEOUT_CYCLES) begin
			@(posedge clk);
			cycles++;
		end
		$display("Timeout: the run did not end within %0d cycles", TIMEOUT_CYCLES);
		$display("Regression failed");
		$finish;
	end

endmodule
